// File: common/lsu_pkg.sv
package lsu_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int LSQ_DEPTH = 8;
    localparam int LSQ_IDX   = $clog2(LSQ_DEPTH);
    localparam int ROB_IDX   = 5;
    localparam int PHY_IDX   = 6;
    localparam int ARCH_IDX  = 5;

    //////////////////////////////////////////////////
    // Memory op encoding
    //////////////////////////////////////////////////

    // Access size field
    localparam logic [1:0] SZ_BYTE = 2'b00;
    localparam logic [1:0] SZ_HALF = 2'b01;
    localparam logic [1:0] SZ_WORD = 2'b10;

    // Loads
    localparam logic [3:0] MEM_LB  = 4'b0000;
    localparam logic [3:0] MEM_LH  = 4'b0001;
    localparam logic [3:0] MEM_LW  = 4'b0010;
    localparam logic [3:0] MEM_LBU = 4'b0100;
    localparam logic [3:0] MEM_LHU = 4'b0101;

    // Stores, top bit set
    localparam logic [3:0] MEM_SB  = 4'b1000;
    localparam logic [3:0] MEM_SH  = 4'b1001;
    localparam logic [3:0] MEM_SW  = 4'b1010;

    // Field view of the op word
    typedef struct packed {
        logic       is_store;
        logic       is_unsigned;
        logic [1:0] size;
    } mem_fields_t;

    // Same four bits, read as raw code or as fields
    typedef union packed {
        logic [3:0]  code;
        mem_fields_t f;
    } mem_op_t;

endpackage

// File: design/agu.sv
`timescale 1ns/1ps

module agu
import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic                ex_valid,
    input  logic [ROB_IDX-1:0]  ex_rob_id,
    input  mem_op_t             ex_op,
    input  logic [XLEN-1:0]     rs1_value,
    input  logic [XLEN-1:0]     rs2_value,
    input  logic [XLEN-1:0]     imm,

    output logic                agu_valid,
    output logic [ROB_IDX-1:0]  agu_rob_id,
    output logic [XLEN-1:0]     agu_addr,
    output logic [3:0]          agu_mask,
    output logic [XLEN-1:0]     agu_wdata
);

    logic [XLEN-1:0]    addr;
    logic [3:0]         mask;
    logic [XLEN-1:0]    wdata;

    assign addr = rs1_value + imm;

    // Lane mask and store data placed in every lane it may land in
    always_comb begin
        unique case (ex_op.f.size)
            SZ_BYTE: begin
                mask  = 4'b0001 << addr[1:0];
                wdata = {4{rs2_value[7:0]}};
            end
            SZ_HALF: begin
                mask  = 4'b0011 << {addr[1], 1'b0};
                wdata = {2{rs2_value[15:0]}};
            end
            default: begin
                mask  = 4'b1111;
                wdata = rs2_value;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            agu_valid <= 1'b0;
        end else begin
            agu_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            agu_rob_id <= ex_rob_id;
            agu_addr   <= addr;
            agu_mask   <= mask;
            agu_wdata  <= wdata;
        end
    end

endmodule

// File: lsq/lsq.sv
`timescale 1ns/1ps

module lsq
import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,

    input  logic                ds_valid,
    input  logic [ROB_IDX-1:0]  ds_rob_id,
    input  mem_op_t             ds_op,
    input  logic [PHY_IDX-1:0]  ds_rd_phy,
    input  logic [ARCH_IDX-1:0] ds_rd_arch,
    output logic                ds_ready,

    input  logic                agu_valid,
    input  logic [ROB_IDX-1:0]  agu_rob_id,
    input  logic [XLEN-1:0]     agu_addr,
    input  logic [3:0]          agu_mask,
    input  logic [XLEN-1:0]     agu_wdata,

    input  logic [ROB_IDX-1:0]  rob_head,

    output logic [XLEN-1:0]     dmem_addr,
    output logic [3:0]          dmem_rmask,
    output logic [3:0]          dmem_wmask,
    output logic [XLEN-1:0]     dmem_wdata,
    input  logic [XLEN-1:0]     dmem_rdata,
    input  logic                dmem_resp,

    output mem_op_t             head_op,
    output logic [1:0]          head_offset,
    output logic [XLEN-1:0]     head_rdata,
    input  logic [XLEN-1:0]     load_value,

    output logic                cdb_valid,
    output logic [ROB_IDX-1:0]  cdb_rob_id,
    output logic [PHY_IDX-1:0]  cdb_rd_phy,
    output logic [ARCH_IDX-1:0] cdb_rd_arch,
    output logic [XLEN-1:0]     cdb_value
);

    logic [ROB_IDX-1:0]     ent_rob_id  [LSQ_DEPTH];
    mem_op_t                ent_op      [LSQ_DEPTH];
    logic [PHY_IDX-1:0]     ent_rd_phy  [LSQ_DEPTH];
    logic [ARCH_IDX-1:0]    ent_rd_arch [LSQ_DEPTH];
    logic [XLEN-1:0]        ent_addr    [LSQ_DEPTH];
    logic [3:0]             ent_mask    [LSQ_DEPTH];
    logic [XLEN-1:0]        ent_wdata   [LSQ_DEPTH];
    logic                   ent_ready   [LSQ_DEPTH];
    logic [LSQ_DEPTH-1:0]   ent_valid;

    logic [LSQ_IDX:0]       wr_ptr;
    logic [LSQ_IDX:0]       rd_ptr;
    logic [LSQ_IDX-1:0]     wr_idx;
    logic [LSQ_IDX-1:0]     rd_idx;

    logic                   full;
    logic                   empty;
    logic                   enqueue;
    logic                   dequeue;
    logic                   head_go;
    logic                   req;
    logic                   pending;
    logic                   flushed;

    //////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////

    assign wr_idx  = wr_ptr[LSQ_IDX-1:0];
    assign rd_idx  = rd_ptr[LSQ_IDX-1:0];
    assign full    = (wr_idx == rd_idx) && (wr_ptr[LSQ_IDX] != rd_ptr[LSQ_IDX]);
    assign empty   = (wr_ptr == rd_ptr);
    assign ds_ready = ~full;
    assign enqueue = ds_valid && ds_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            ent_valid <= '0;
        end else begin
            if (enqueue) begin
                wr_ptr            <= wr_ptr + 1'b1;
                ent_valid[wr_idx] <= 1'b1;
            end
            if (dequeue) begin
                rd_ptr            <= rd_ptr + 1'b1;
                ent_valid[rd_idx] <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Entry fill
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // Address result lands on the live entry with the same ROB index
        if (agu_valid) begin
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                if (ent_valid[i] && (ent_rob_id[i] == agu_rob_id)) begin
                    ent_ready[i] <= 1'b1;
                    ent_addr[i]  <= agu_addr;
                    ent_mask[i]  <= agu_mask;
                    ent_wdata[i] <= agu_wdata;
                end
            end
        end
        if (enqueue) begin
            ent_rob_id[wr_idx]  <= ds_rob_id;
            ent_op[wr_idx]      <= ds_op;
            ent_rd_phy[wr_idx]  <= ds_rd_phy;
            ent_rd_arch[wr_idx] <= ds_rd_arch;
            ent_ready[wr_idx]   <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Memory access
    //////////////////////////////////////////////////

    // Stores go only once they reach the ROB head
    assign head_go = !empty && ent_ready[rd_idx] &&
                     (!ent_op[rd_idx].f.is_store || (rob_head == ent_rob_id[rd_idx]));
    assign req     = head_go && !pending && !dmem_resp && !flush;

    assign dmem_rmask = (req && !ent_op[rd_idx].f.is_store) ? ent_mask[rd_idx] : 4'b0000;
    assign dmem_wmask = (req &&  ent_op[rd_idx].f.is_store) ? ent_mask[rd_idx] : 4'b0000;
    assign dmem_addr  = {ent_addr[rd_idx][XLEN-1:2], 2'b00};
    assign dmem_wdata = ent_wdata[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (req) begin
            pending <= 1'b1;
        end else if (dmem_resp) begin
            pending <= 1'b0;
        end
    end

    // Response of an access cut off by flush is swallowed
    always_ff @(posedge clk) begin
        if (rst) begin
            flushed <= 1'b0;
        end else if (dmem_resp) begin
            flushed <= 1'b0;
        end else if (flush && pending) begin
            flushed <= 1'b1;
        end
    end

    assign dequeue = pending && dmem_resp && !flushed && !flush;

    //////////////////////////////////////////////////
    // Extender feed and broadcast
    //////////////////////////////////////////////////

    assign head_op     = ent_op[rd_idx];
    assign head_offset = ent_addr[rd_idx][1:0];
    assign head_rdata  = dmem_resp ? dmem_rdata : '0;

    assign cdb_valid   = dequeue;
    assign cdb_rob_id  = ent_rob_id[rd_idx];
    assign cdb_rd_phy  = ent_rd_phy[rd_idx];
    assign cdb_rd_arch = ent_rd_arch[rd_idx];
    assign cdb_value   = load_value;

endmodule

// File: design/load_extend.sv
`timescale 1ns/1ps

module load_extend
import lsu_pkg::*;
(
    input  mem_op_t             op,
    input  logic [1:0]          offset,
    input  logic [XLEN-1:0]     rdata,
    output logic [XLEN-1:0]     value
);

    logic [7:0]     byte_lane;
    logic [15:0]    half_lane;

    // Lane picked by the low address bits
    assign byte_lane = rdata[{offset, 3'b000} +: 8];
    assign half_lane = rdata[{offset[1], 4'b0000} +: 16];

    always_comb begin
        unique case (op.code)
            MEM_LB: begin
                value = {{24{byte_lane[7]}}, byte_lane};
            end
            MEM_LBU: begin
                value = {24'b0, byte_lane};
            end
            MEM_LH: begin
                value = {{16{half_lane[15]}}, half_lane};
            end
            MEM_LHU: begin
                value = {16'b0, half_lane};
            end
            MEM_LW: begin
                value = rdata;
            end
            // Stores broadcast zero
            default: begin
                value = '0;
            end
        endcase
    end

endmodule

// File: design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic [ROB_IDX-1:0]  rob_head,

    input  logic                ds_valid,
    input  logic [ROB_IDX-1:0]  ds_rob_id,
    input  mem_op_t             ds_op,
    input  logic [PHY_IDX-1:0]  ds_rd_phy,
    input  logic [ARCH_IDX-1:0] ds_rd_arch,
    output logic                ds_ready,

    input  logic                ex_valid,
    input  logic [ROB_IDX-1:0]  ex_rob_id,
    input  mem_op_t             ex_op,
    input  logic [XLEN-1:0]     rs1_value,
    input  logic [XLEN-1:0]     rs2_value,
    input  logic [XLEN-1:0]     imm,

    output logic [XLEN-1:0]     dmem_addr,
    output logic [3:0]          dmem_rmask,
    output logic [3:0]          dmem_wmask,
    output logic [XLEN-1:0]     dmem_wdata,
    input  logic [XLEN-1:0]     dmem_rdata,
    input  logic                dmem_resp,

    output logic                cdb_valid,
    output logic [ROB_IDX-1:0]  cdb_rob_id,
    output logic [PHY_IDX-1:0]  cdb_rd_phy,
    output logic [ARCH_IDX-1:0] cdb_rd_arch,
    output logic [XLEN-1:0]     cdb_value
);

    logic                   agu_valid;
    logic [ROB_IDX-1:0]     agu_rob_id;
    logic [XLEN-1:0]        agu_addr;
    logic [3:0]             agu_mask;
    logic [XLEN-1:0]        agu_wdata;

    mem_op_t                head_op;
    logic [1:0]             head_offset;
    logic [XLEN-1:0]        head_rdata;
    logic [XLEN-1:0]        load_value;

    agu u_agu (
        .clk, .rst,
        .ex_valid, .ex_rob_id, .ex_op, .rs1_value, .rs2_value, .imm,
        .agu_valid, .agu_rob_id, .agu_addr, .agu_mask, .agu_wdata
    );

    lsq u_lsq (
        .clk, .rst, .flush,
        .ds_valid, .ds_rob_id, .ds_op, .ds_rd_phy, .ds_rd_arch, .ds_ready,
        .agu_valid, .agu_rob_id, .agu_addr, .agu_mask, .agu_wdata,
        .rob_head,
        .dmem_addr, .dmem_rmask, .dmem_wmask, .dmem_wdata, .dmem_rdata, .dmem_resp,
        .head_op, .head_offset, .head_rdata, .load_value,
        .cdb_valid, .cdb_rob_id, .cdb_rd_phy, .cdb_rd_arch, .cdb_value
    );

    load_extend u_load_extend (
        .op     (head_op),
        .offset (head_offset),
        .rdata  (head_rdata),
        .value  (load_value)
    );

endmodule

// File: dv/lsu_chk.sv
`timescale 1ns/1ps

module lsu_chk (
    input  logic                clk,
    input  logic                rst,
    input  logic [3:0]          dmem_rmask,
    input  logic [3:0]          dmem_wmask,
    input  logic                dmem_resp,
    input  logic                cdb_valid
);

    int                 violations = 0;
    logic               req;
    logic               outstanding;

    assign req = |dmem_rmask || |dmem_wmask;

    // Access in flight, as seen on the memory port
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (req) begin
            outstanding <= 1'b1;
        end else if (dmem_resp) begin
            outstanding <= 1'b0;
        end
    end

    mask_excl: assert property (@(posedge clk) disable iff (rst)
        !(|dmem_rmask && |dmem_wmask))
    else begin
        $error("read and write masks active together");
        violations++;
    end

    // Single outstanding access
    req_alone: assert property (@(posedge clk) disable iff (rst)
        req |-> !outstanding && !dmem_resp)
    else begin
        $error("request overlaps a pending access");
        violations++;
    end

    cdb_on_resp: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> dmem_resp && outstanding)
    else begin
        $error("broadcast without a memory response");
        violations++;
    end

endmodule

bind lsq lsu_chk u_chk (
    .clk, .rst, .dmem_rmask, .dmem_wmask, .dmem_resp, .cdb_valid
);

// File: dv/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu
import lsu_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int WAIT_LIMIT    = 40;
    // Worst case per test: 13 loads, store pair, reverse set, full queue, flush
    localparam int TEST_CYCLES   = 13 * 30 + 80 + 100 + 160 + 100;
    localparam int MARGIN_CYCLES = 200;

    logic clk, rst, flush, ds_valid, ds_ready, ex_valid, dmem_resp, cdb_valid;
    logic [ROB_IDX-1:0] rob_head, ds_rob_id, ex_rob_id, cdb_rob_id;
    logic [PHY_IDX-1:0] ds_rd_phy, cdb_rd_phy;
    logic [ARCH_IDX-1:0] ds_rd_arch, cdb_rd_arch;
    mem_op_t ds_op, ex_op;
    logic [XLEN-1:0] rs1_value, rs2_value, imm, dmem_addr, dmem_wdata, dmem_rdata, cdb_value;
    logic [3:0] dmem_rmask, dmem_wmask;

    // Memory model state and broadcast log
    logic [XLEN-1:0] mem [64];
    logic [XLEN-1:0] rd_word;
    logic [3:0] last_rmask, last_wmask;
    int lat_cnt, force_lat, rd_req_cnt, wr_req_cnt;
    bit mem_busy;
    logic [ROB_IDX-1:0] cdb_rob_q [$];
    logic [PHY_IDX-1:0] cdb_phy_q [$];
    logic [ARCH_IDX-1:0] cdb_arch_q [$];
    logic [XLEN-1:0] cdb_val_q [$];
    logic [ROB_IDX-1:0] next_rob;

    lsu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic logic [XLEN-1:0] fill_word(input int idx);
        return 32'hC3A5_0000 ^ (idx * 32'h0104_0907) ^ idx;
    endfunction

    // Shift the addressed lane down, then extend
    function automatic logic [XLEN-1:0] expect_load(input logic [3:0] op,
                                                   input logic [XLEN-1:0] word, input int off);
        logic [XLEN-1:0] lane;
        lane = word >> (8 * off);
        case (op)
            MEM_LB:  return XLEN'($signed(lane[7:0]));
            MEM_LBU: return XLEN'(lane[7:0]);
            MEM_LH:  return XLEN'($signed(lane[15:0]));
            MEM_LHU: return XLEN'(lane[15:0]);
            default: return word;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] merge_store(input logic [XLEN-1:0] old,
                                                   input logic [XLEN-1:0] data,
                                                   input int nbytes, input int off);
        logic [XLEN-1:0] res;
        res = old;
        for (int b = 0; b < nbytes; b++) begin
            res[8*(off+b) +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic dispatch(input logic [ROB_IDX-1:0] rob, input logic [3:0] op);
        @(negedge clk);
        assert (ds_ready) else stop_run("Dispatch refused although the queue has room");
        ds_valid   = 1'b1;
        ds_rob_id  = rob;
        ds_op.code = op;
        ds_rd_phy  = {1'b1, rob};
        ds_rd_arch = rob;
        @(negedge clk);
        ds_valid = 1'b0;
    endtask

    task automatic execute(input logic [ROB_IDX-1:0] rob, input logic [3:0] op,
                           input logic [XLEN-1:0] base, input logic [XLEN-1:0] data,
                           input logic [XLEN-1:0] offset);
        @(negedge clk);
        ex_valid   = 1'b1;
        ex_rob_id  = rob;
        ex_op.code = op;
        rs1_value  = base;
        rs2_value  = data;
        imm        = offset;
        @(negedge clk);
        ex_valid = 1'b0;
    endtask

    task automatic wait_cdb(input logic [ROB_IDX-1:0] rob, input logic [XLEN-1:0] value);
        int cycles = 0;
        while (cdb_rob_q.size() == 0) begin
            @(negedge clk);
            cycles++;
            assert (cycles <= WAIT_LIMIT) else stop_run("No broadcast arrived in time");
        end
        check_value("cdb_rob_id", cdb_rob_q.pop_front(), rob);
        check_value("cdb_rd_phy", cdb_phy_q.pop_front(), {1'b1, rob});
        check_value("cdb_rd_arch", cdb_arch_q.pop_front(), rob);
        check_value("cdb_value", cdb_val_q.pop_front(), value);
    endtask

    //////////////////////////////////////////////////
    // Memory model and broadcast monitor
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(30));
        for (int i = 0; i < 64; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            @(negedge clk);
            dmem_resp = 1'b0;
            if (mem_busy && lat_cnt == 1) begin
                dmem_resp  = 1'b1;
                dmem_rdata = rd_word;
                mem_busy   = 1'b0;
            end else if (mem_busy) begin
                lat_cnt--;
            end
            // Sample late in the cycle, well clear of both edges
            #(CLK_PERIOD/4);
            if (cdb_valid) begin
                cdb_rob_q.push_back(cdb_rob_id);
                cdb_phy_q.push_back(cdb_rd_phy);
                cdb_arch_q.push_back(cdb_rd_arch);
                cdb_val_q.push_back(cdb_value);
            end
            if (|dmem_rmask || |dmem_wmask) begin
                assert (dmem_addr[1:0] == 2'b00) else begin
                    stop_run($sformatf("error at %0t: dmem_addr %h is not word aligned",
                                       $time, dmem_addr));
                end
                last_rmask = dmem_rmask;
                last_wmask = dmem_wmask;
                rd_word = mem[dmem_addr[7:2]];
                for (int b = 0; b < 4; b++) begin
                    if (dmem_wmask[b]) mem[dmem_addr[7:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
                end
                if (|dmem_wmask) wr_req_cnt++;
                else rd_req_cnt++;
                lat_cnt  = (force_lat > 0) ? force_lat : $urandom_range(4, 1);
                mem_busy = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic sweep_load_widths();
        logic [3:0] ops [5] = '{MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
        int nbytes [5] = '{1, 1, 2, 2, 4};
        mem[5] = 32'h81F2_7F93;
        for (int k = 0; k < 5; k++) begin
            for (int off = 0; off < 4; off += nbytes[k]) begin
                dispatch(next_rob, ops[k]);
                execute(next_rob, ops[k], 32'd20, 32'd0, off);
                wait_cdb(next_rob, expect_load(ops[k], 32'h81F2_7F93, off));
                // One lane bit per byte read, starting at the offset
                check_value("dmem_rmask", last_rmask, ((1 << nbytes[k]) - 1) << off);
                next_rob++;
            end
        end
    endtask

    task automatic store_waits_rob_head();
        int wr_before = wr_req_cnt;
        mem[9]   = 32'h1122_3344;
        rob_head = next_rob + 5'd3;
        dispatch(next_rob, MEM_SH);
        execute(next_rob, MEM_SH, 32'd36, 32'h0000_BEEF, 32'd2);
        repeat (10) @(negedge clk);
        assert (wr_req_cnt == wr_before) else stop_run("Store went to memory before ROB head");
        rob_head = next_rob;
        wait_cdb(next_rob, 32'd0);
        assert (wr_req_cnt == wr_before + 1) else stop_run("Store did not write memory once");
        // Halfword at byte 2 covers the upper two lanes
        check_value("dmem_wmask", last_wmask, 4'b1100);
        next_rob++;
        dispatch(next_rob, MEM_LW);
        execute(next_rob, MEM_LW, 32'd36, 32'd0, 32'd0);
        wait_cdb(next_rob, merge_store(32'h1122_3344, 32'h0000_BEEF, 2, 2));
        next_rob++;
    endtask

    task automatic reverse_address_order();
        for (int i = 0; i < 4; i++) dispatch(next_rob + i, MEM_LW);
        for (int i = 3; i >= 0; i--) execute(next_rob + i, MEM_LW, 32'd40 + 4 * i, 0, 0);
        // Completion follows enqueue order
        for (int i = 0; i < 4; i++) wait_cdb(next_rob + i, fill_word(10 + i));
        next_rob += 4;
    endtask

    task automatic fill_queue();
        for (int i = 0; i < LSQ_DEPTH; i++) dispatch(next_rob + i, MEM_LBU);
        assert (!ds_ready) else stop_run("ds_ready stayed high with the queue full");
        execute(next_rob, MEM_LBU, 32'd44, 32'd0, 32'd1);
        wait_cdb(next_rob, expect_load(MEM_LBU, fill_word(11), 1));
        assert (ds_ready) else stop_run("ds_ready stayed low after an access completed");
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        next_rob += LSQ_DEPTH;
    endtask

    task automatic flush_pending_access();
        int rd_before = rd_req_cnt;
        int cycles = 0;
        force_lat = 4;
        dispatch(next_rob, MEM_LW);
        execute(next_rob, MEM_LW, 32'd48, 32'd0, 32'd0);
        while (rd_req_cnt == rd_before) begin
            @(negedge clk);
            cycles++;
            assert (cycles <= WAIT_LIMIT) else stop_run("Load never reached memory");
        end
        flush = 1'b1;
        @(negedge clk);
        flush     = 1'b0;
        force_lat = 0;
        // New op enters while the cut off access is still out
        next_rob++;
        dispatch(next_rob, MEM_LH);
        execute(next_rob, MEM_LH, 32'd52, 32'd0, 32'd2);
        wait_cdb(next_rob, expect_load(MEM_LH, fill_word(13), 2));
        assert (cdb_rob_q.size() == 0) else stop_run("Unexpected extra broadcast after flush");
        next_rob++;
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        rob_head = '0;
        ds_valid = 1'b0;
        ds_rob_id = '0;
        ds_op = '0;
        ds_rd_phy = '0;
        ds_rd_arch = '0;
        ex_valid = 1'b0;
        ex_rob_id = '0;
        ex_op = '0;
        rs1_value = '0;
        rs2_value = '0;
        imm = '0;
        dmem_rdata = '0;
        dmem_resp = 1'b0;
        next_rob = 5'd1;
        rob_head = 5'd31;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        assert (ds_ready && !cdb_valid && dmem_rmask == 0 && dmem_wmask == 0 &&
                !DUT.u_agu.agu_valid) else stop_run("Outputs not idle after reset");
        sweep_load_widths();
        store_waits_rob_head();
        reverse_address_order();
        fill_queue();
        flush_pending_access();
        repeat (5) @(negedge clk);
        if (DUT.u_lsq.u_chk.violations == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "bound assertions failed");
        end
    end

    initial begin
        wait (DUT.u_lsq.u_chk.violations != 0);
        stop_run("A bound assertion on the memory port or broadcast failed");
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        stop_run("Watchdog expired before the tests finished");
    end

endmodule

// File: tb.f
common/lsu_pkg.sv
design/agu.sv
lsq/lsq.sv
design/load_extend.sv
design/lsu_top.sv
dv/lsu_chk.sv
dv/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - common/lsu_pkg.sv
      - design/agu.sv
      - lsq/lsq.sv
      - design/load_extend.sv
      - design/lsu_top.sv
  - target: test
    files:
      - dv/lsu_chk.sv
      - dv/tb_lsu.sv
